// File: logic/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// ----------------------------------------
// address spaces, addr[15:12]
// ----------------------------------------
`define ADDR_MAIN         4'h0      // board and axis registers
`define ADDR_DATA_BUF     4'h5      // block sample buffer

// ----------------------------------------
// register offsets, addr[3:0]
// ----------------------------------------
`define OFF_ADC_DATA      4'h0      // axis current feedback
`define OFF_DAC_CTRL      4'h1      // axis current command
`define REG_STATUS        4'h0      // channel 0 status word
`define STATUS_PWR_BIT    19        // power enable in status

// ----------------------------------------
// safety and sampler limits
// ----------------------------------------
`define SAFETY_MARGIN     16'h0800  // current counts of slack
`define SAFETY_TRIP_COUNT 5         // consecutive bad cycles to trip
`define SAMPLE_WORDS      5         // timestamp + 4 adc words
`define NUM_AXES          4

`endif

// File: logic/board_pkg.sv
`default_nettype none

package board_pkg;

    // bus address: space [15:12], chan [7:4], offset [3:0]
    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;       // register word
    typedef logic [3:0]  space_t;
    typedef logic [3:0]  chan_t;       // 0 = board, 1..4 = axes
    typedef logic [3:0]  offset_t;

    // offset binary, midscale 16'h8000
    typedef logic [15:0] cur_t;

    typedef logic [3:0]  board_id_t;   // rotary switch
    typedef logic [3:0]  amp_mask_t;   // bit 0 is axis 1
    typedef logic [2:0]  sample_addr_t;

    // block sampler fsm
    typedef enum logic {
        SAMPLE_IDLE,
        SAMPLE_RUN
    } sample_state_t;

endpackage

`default_nettype wire

// File: logic/reg_bus_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module reg_bus_router (
    input  board_pkg::addr_t fw_reg_raddr,
    input  board_pkg::addr_t fw_reg_waddr,
    input  board_pkg::addr_t eth_reg_raddr,
    input  board_pkg::addr_t eth_reg_waddr,
    input  board_pkg::data_t fw_reg_wdata,
    input  board_pkg::data_t eth_reg_wdata,
    input  logic             fw_reg_wen,
    input  logic             eth_reg_wen,
    input  logic             eth_read_en,    // eth owns the read address
    input  logic             sample_busy,    // sampler owns the read address
    input  board_pkg::chan_t sample_chan,
    input  board_pkg::data_t status_rdata,
    input  board_pkg::data_t dac_rdata,
    input  board_pkg::data_t sample_rdata,
    input  board_pkg::cur_t  cur_fb1,
    input  board_pkg::cur_t  cur_fb2,
    input  board_pkg::cur_t  cur_fb3,
    input  board_pkg::cur_t  cur_fb4,
    output board_pkg::addr_t bus_raddr,
    output board_pkg::addr_t bus_waddr,
    output board_pkg::data_t bus_wdata,
    output logic             bus_wen,
    output board_pkg::data_t reg_rdata
);
    import board_pkg::*;

    space_t  rd_space;
    chan_t   rd_chan;
    offset_t rd_off;
    data_t   adc_word;      // feedback of the addressed axis

    // ----------------------------------------
    // address arbitration
    // ----------------------------------------
    // sampler > eth > firewire
    assign bus_raddr = sample_busy ? {`ADDR_MAIN, 4'd0, sample_chan, `OFF_ADC_DATA} :
                       eth_read_en ? eth_reg_raddr :
                                     fw_reg_raddr;

    // eth wins a same-cycle write
    assign bus_waddr = eth_reg_wen ? eth_reg_waddr : fw_reg_waddr;
    assign bus_wdata = eth_reg_wen ? eth_reg_wdata : fw_reg_wdata;
    assign bus_wen   = fw_reg_wen | eth_reg_wen;

    assign rd_space = bus_raddr[15:12];
    assign rd_chan  = bus_raddr[7:4];
    assign rd_off   = bus_raddr[3:0];

    // adc word, upper half unused here
    always_comb begin
        case (rd_chan)
            4'd1:    adc_word = {16'd0, cur_fb1};
            4'd2:    adc_word = {16'd0, cur_fb2};
            4'd3:    adc_word = {16'd0, cur_fb3};
            4'd4:    adc_word = {16'd0, cur_fb4};
            default: adc_word = '0;     // no such axis
        endcase
    end

    // ----------------------------------------
    // read data decode
    // ----------------------------------------
    always_comb begin
        reg_rdata = '0;                             // dropped spaces read zero
        if (rd_space == `ADDR_DATA_BUF) begin
            reg_rdata = sample_rdata;
        end else if (rd_space == `ADDR_MAIN) begin
            if (rd_chan == 4'd0)
                reg_rdata = status_rdata;           // board channel
            else if (rd_off == `OFF_ADC_DATA)
                reg_rdata = adc_word;
            else if (rd_off == `OFF_DAC_CTRL)
                reg_rdata = dac_rdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/dac_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module dac_cmd_regs (
    input  logic             sysclk,
    input  logic             rst_n,
    input  board_pkg::addr_t bus_waddr,
    input  board_pkg::addr_t bus_raddr,
    input  board_pkg::data_t bus_wdata,
    input  logic             bus_wen,
    output board_pkg::data_t dac_rdata,
    output board_pkg::cur_t  cur_cmd1,
    output board_pkg::cur_t  cur_cmd2,
    output board_pkg::cur_t  cur_cmd3,
    output board_pkg::cur_t  cur_cmd4
);
    import board_pkg::*;

    cur_t  cmd [1:`NUM_AXES];   // command per axis
    chan_t wchan;
    chan_t rchan;
    logic  wr_hit;

    assign wchan = bus_waddr[7:4];
    assign rchan = bus_raddr[7:4];

    // main space, axis 1..4, dac offset
    assign wr_hit = bus_wen && (bus_waddr[15:12] == `ADDR_MAIN) &&
                    (wchan >= 4'd1) && (wchan <= chan_t'(`NUM_AXES)) &&
                    (bus_waddr[3:0] == `OFF_DAC_CTRL);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 1; i <= `NUM_AXES; i++)
                cmd[i] <= '0;
        end else if (wr_hit) begin
            cmd[wchan] <= bus_wdata[15:0];  // low half only
        end
    end

    // readback of the addressed axis
    assign dac_rdata = ((rchan >= 4'd1) && (rchan <= chan_t'(`NUM_AXES))) ?
                       {16'd0, cmd[rchan]} : '0;

    assign cur_cmd1 = cmd[1];
    assign cur_cmd2 = cmd[2];
    assign cur_cmd3 = cmd[3];
    assign cur_cmd4 = cmd[4];

endmodule

`default_nettype wire

// File: logic/safety_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module safety_check (
    input  logic            sysclk,
    input  logic            rst_n,
    input  board_pkg::cur_t cur_fb,
    input  board_pkg::cur_t cur_cmd,
    input  logic            clear_disable,  // pulse from status write
    output logic            amp_disable
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(`SAFETY_TRIP_COUNT + 1);

    cur_t             fb_mag;
    cur_t             cmd_mag;
    logic [17:0]      limit;        // 2*cmd + margin, no overflow
    logic             violate;
    logic [CNT_W-1:0] bad_cnt;      // consecutive violating cycles

    // distance from midscale
    assign fb_mag  = cur_fb[15]  ? (cur_fb  - 16'h8000) : (16'h8000 - cur_fb);
    assign cmd_mag = cur_cmd[15] ? (cur_cmd - 16'h8000) : (16'h8000 - cur_cmd);

    assign limit   = {1'b0, cmd_mag, 1'b0} + {2'b00, `SAFETY_MARGIN};
    assign violate = {2'b00, fb_mag} > limit;

    // ----------------------------------------
    // counter and disable latch
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            bad_cnt     <= '0;
            amp_disable <= 1'b0;
        end else begin
            if (!violate) begin
                bad_cnt <= '0;
            end else if (bad_cnt == CNT_W'(`SAFETY_TRIP_COUNT - 1)) begin
                bad_cnt     <= '0;      // restart, can trip again
                amp_disable <= 1'b1;
            end else begin
                bad_cnt <= bad_cnt + 1'b1;
            end
            if (clear_disable)
                amp_disable <= 1'b0;    // clear wins over a trip
        end
    end

endmodule

`default_nettype wire

// File: logic/board_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module board_regs (
    input  logic                 sysclk,
    input  logic                 rst_n,
    input  board_pkg::addr_t     bus_waddr,
    input  board_pkg::data_t     bus_wdata,
    input  logic                 bus_wen,
    input  board_pkg::board_id_t board_id,
    input  board_pkg::amp_mask_t safety_disable,   // latched by the checkers
    output board_pkg::data_t     status_rdata,
    output logic                 pwr_enable,
    output board_pkg::amp_mask_t amp_enable,
    output board_pkg::amp_mask_t clear_disable
);
    import board_pkg::*;

    amp_mask_t amp_en_cmd;  // enables as written by the host
    logic      status_wr;
    logic      pwr_bit;

    // main space, channel 0, status offset
    assign status_wr = bus_wen &&
                       (bus_waddr == {`ADDR_MAIN, 4'd0, 4'd0, `REG_STATUS});
    assign pwr_bit   = bus_wdata[`STATUS_PWR_BIT];

    // ----------------------------------------
    // enables and clear pulses
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            pwr_enable    <= 1'b0;
            amp_en_cmd    <= '0;
            clear_disable <= '0;
        end else begin
            clear_disable <= '0;                    // one cycle only
            if (status_wr) begin
                pwr_enable    <= pwr_bit;
                amp_en_cmd    <= bus_wdata[3:0];
                // power bit clears all, amp bit clears its axis
                clear_disable <= {4{pwr_bit}} | bus_wdata[3:0];
            end
        end
    end

    // drops in the same cycle as a trip
    assign amp_enable = amp_en_cmd & ~safety_disable;

    // status word layout
    always_comb begin
        status_rdata                  = '0;
        status_rdata[3:0]             = amp_en_cmd;
        status_rdata[7:4]             = safety_disable;
        status_rdata[`STATUS_PWR_BIT] = pwr_enable;
        status_rdata[27:24]           = board_id;
    end

endmodule

`default_nettype wire

// File: logic/block_sampler.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module block_sampler (
    input  logic             sysclk,
    input  logic             rst_n,
    input  logic             sample_start,  // one-cycle request
    input  board_pkg::addr_t bus_raddr,
    input  board_pkg::data_t reg_rdata,     // adc word during busy
    output logic             sample_busy,
    output board_pkg::chan_t sample_chan,
    output board_pkg::data_t sample_rdata
);
    import board_pkg::*;

    sample_state_t state;
    sample_addr_t  idx;                     // word being captured
    sample_addr_t  rd_idx;
    data_t         timestamp;               // free running
    data_t         buffer [`SAMPLE_WORDS];

    always_ff @(posedge sysclk) begin
        if (!rst_n)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    // ----------------------------------------
    // sample fsm
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state <= SAMPLE_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                SAMPLE_IDLE: begin
                    idx <= '0;
                    if (sample_start)
                        state <= SAMPLE_RUN;
                end
                SAMPLE_RUN: begin       // start ignored here
                    idx <= idx + 1'b1;
                    if (idx == sample_addr_t'(`SAMPLE_WORDS - 1))
                        state <= SAMPLE_IDLE;
                end
                default: state <= SAMPLE_IDLE;
            endcase
        end
    end

    // word 0 is the timestamp, the rest come off the bus
    always_ff @(posedge sysclk) begin
        if (state == SAMPLE_RUN)
            buffer[idx] <= (idx == '0) ? timestamp : reg_rdata;
    end

    assign sample_busy = (state == SAMPLE_RUN);
    assign sample_chan = {1'b0, idx};       // chan n -> word n

    assign rd_idx       = bus_raddr[2:0];
    assign sample_rdata = (rd_idx < sample_addr_t'(`SAMPLE_WORDS)) ? buffer[rd_idx] : '0;

endmodule

`default_nettype wire

// File: logic/motor_board_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "board_macros.svh"

module motor_board_top (
    input  logic                 sysclk,
    input  logic                 rst_n,
    // firewire host
    input  board_pkg::addr_t     fw_reg_raddr,
    input  board_pkg::addr_t     fw_reg_waddr,
    input  board_pkg::data_t     fw_reg_wdata,
    input  logic                 fw_reg_wen,
    // ethernet host
    input  board_pkg::addr_t     eth_reg_raddr,
    input  board_pkg::addr_t     eth_reg_waddr,
    input  board_pkg::data_t     eth_reg_wdata,
    input  logic                 eth_reg_wen,
    input  logic                 eth_read_en,
    input  logic                 eth_sample_start,
    output logic                 sample_busy,
    output board_pkg::data_t     reg_rdata,     // shared by both hosts
    input  board_pkg::board_id_t board_id,
    input  board_pkg::cur_t      cur_fb1,
    input  board_pkg::cur_t      cur_fb2,
    input  board_pkg::cur_t      cur_fb3,
    input  board_pkg::cur_t      cur_fb4,
    output board_pkg::cur_t      cur_cmd1,
    output board_pkg::cur_t      cur_cmd2,
    output board_pkg::cur_t      cur_cmd3,
    output board_pkg::cur_t      cur_cmd4,
    output logic                 pwr_enable,
    output board_pkg::amp_mask_t amp_enable
);
    import board_pkg::*;

    addr_t     bus_raddr;
    addr_t     bus_waddr;
    data_t     bus_wdata;
    logic      bus_wen;
    data_t     status_rdata;
    data_t     dac_rdata;
    data_t     sample_rdata;
    chan_t     sample_chan;
    amp_mask_t safety_disable;
    amp_mask_t clear_disable;
    cur_t      fb_vec  [`NUM_AXES];     // axis 1 at index 0
    cur_t      cmd_vec [`NUM_AXES];

    assign fb_vec  = '{cur_fb1, cur_fb2, cur_fb3, cur_fb4};
    assign cmd_vec = '{cur_cmd1, cur_cmd2, cur_cmd3, cur_cmd4};

    // ----------------------------------------
    // bus and register blocks
    // ----------------------------------------
    reg_bus_router router (
        .fw_reg_raddr  (fw_reg_raddr),
        .fw_reg_waddr  (fw_reg_waddr),
        .eth_reg_raddr (eth_reg_raddr),
        .eth_reg_waddr (eth_reg_waddr),
        .fw_reg_wdata  (fw_reg_wdata),
        .eth_reg_wdata (eth_reg_wdata),
        .fw_reg_wen    (fw_reg_wen),
        .eth_reg_wen   (eth_reg_wen),
        .eth_read_en   (eth_read_en),
        .sample_busy   (sample_busy),
        .sample_chan   (sample_chan),
        .status_rdata  (status_rdata),
        .dac_rdata     (dac_rdata),
        .sample_rdata  (sample_rdata),
        .cur_fb1       (cur_fb1),
        .cur_fb2       (cur_fb2),
        .cur_fb3       (cur_fb3),
        .cur_fb4       (cur_fb4),
        .bus_raddr     (bus_raddr),
        .bus_waddr     (bus_waddr),
        .bus_wdata     (bus_wdata),
        .bus_wen       (bus_wen),
        .reg_rdata     (reg_rdata)
    );

    dac_cmd_regs dac (
        .sysclk    (sysclk),
        .rst_n     (rst_n),
        .bus_waddr (bus_waddr),
        .bus_raddr (bus_raddr),
        .bus_wdata (bus_wdata),
        .bus_wen   (bus_wen),
        .dac_rdata (dac_rdata),
        .cur_cmd1  (cur_cmd1),
        .cur_cmd2  (cur_cmd2),
        .cur_cmd3  (cur_cmd3),
        .cur_cmd4  (cur_cmd4)
    );

    board_regs chan0 (                  // channel 0 status
        .sysclk         (sysclk),
        .rst_n          (rst_n),
        .bus_waddr      (bus_waddr),
        .bus_wdata      (bus_wdata),
        .bus_wen        (bus_wen),
        .board_id       (board_id),
        .safety_disable (safety_disable),
        .status_rdata   (status_rdata),
        .pwr_enable     (pwr_enable),
        .amp_enable     (amp_enable),
        .clear_disable  (clear_disable)
    );

    block_sampler sampler (
        .sysclk       (sysclk),
        .rst_n        (rst_n),
        .sample_start (eth_sample_start),
        .bus_raddr    (bus_raddr),
        .reg_rdata    (reg_rdata),      // adc word while busy
        .sample_busy  (sample_busy),
        .sample_chan  (sample_chan),
        .sample_rdata (sample_rdata)
    );

    // ----------------------------------------
    // over-current checkers, one per axis
    // ----------------------------------------
    for (genvar i = 0; i < `NUM_AXES; i++) begin : g_safe
        safety_check safe (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_fb        (fb_vec[i]),
            .cur_cmd       (cmd_vec[i]),
            .clear_disable (clear_disable[i]),
            .amp_disable   (safety_disable[i])
        );
    end

endmodule

`default_nettype wire

// File: verification/tb_motor_board.sv
`timescale 1ns/1ps
`default_nettype none

module tb_motor_board;
    import board_pkg::*;

    localparam int MAX_CYCLES = 2000;   // trace runs well under 200 cycles

    logic      sysclk;
    logic      rst_n;
    addr_t     fw_reg_raddr;
    addr_t     fw_reg_waddr;
    data_t     fw_reg_wdata;
    logic      fw_reg_wen;
    addr_t     eth_reg_raddr;
    addr_t     eth_reg_waddr;
    data_t     eth_reg_wdata;
    logic      eth_reg_wen;
    logic      eth_read_en;
    logic      eth_sample_start;
    logic      sample_busy;
    data_t     reg_rdata;
    board_id_t board_id;
    cur_t      cur_fb1;
    cur_t      cur_fb2;
    cur_t      cur_fb3;
    cur_t      cur_fb4;
    cur_t      cur_cmd1;
    cur_t      cur_cmd2;
    cur_t      cur_cmd3;
    cur_t      cur_cmd4;
    logic      pwr_enable;
    amp_mask_t amp_enable;

    // trace fields
    int        fd;
    int        rc;
    int        cycles = 0;
    string     op;
    string     skip_line;
    logic      t_bit_a;
    logic      t_bit_b;
    addr_t     t_addr_a;
    addr_t     t_addr_b;
    data_t     t_data_a;
    data_t     t_data_b;
    int        t_chan;
    int        t_count;
    cur_t      t_cur;
    amp_mask_t t_mask;
    board_id_t t_id;
    data_t     first_stamp;     // word 0 of the first block sample
    data_t     stamp;
    logic      exp_pwr;         // power enable from the last status write

    motor_board_top DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    // ----------------------------------------
    // failure and compare tasks
    // ----------------------------------------
    task automatic end_in_failure();
        $display("tests failed");
        $fatal(1, "run stopped");
    endtask

    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the trace did not finish within %0d cycles", MAX_CYCLES);
            end_in_failure();
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s gave %h, expected %h", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_mask(input amp_mask_t got, input amp_mask_t exp);
        if (got !== exp) begin
            $display("Fail %0t ns: amp_enable %b, expected %b", $time, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_cur(input cur_t got, input cur_t exp, input int chan);
        if (got !== exp) begin
            $display("Fail %0t ns: cur_cmd%0d %h, expected %h", $time, chan, got, exp);
            end_in_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail %0t ns: %s %b, expected %b", $time, what, got, exp);
            end_in_failure();
        end
    endtask

    // second timestamp has to be later than the first
    task automatic check_later(input data_t got, input data_t earlier);
        if (!(got > earlier)) begin
            $display("Fail %0t ns: timestamp %h not after %h", $time, got, earlier);
            end_in_failure();
        end
    endtask

    task automatic need_fields(input int got, input int want);
        if (got != want) begin
            $display("malformed trace line for opcode %s", op);
            end_in_failure();
        end
    endtask

    // ----------------------------------------
    // drive tasks
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge sysclk);
        #2;                             // drive just after the edge
    endtask

    task automatic drive_write(input logic fw_wen, input addr_t fw_addr, input data_t fw_data,
                               input logic eth_wen, input addr_t eth_addr, input data_t eth_data);
        fw_reg_wen    = fw_wen;
        fw_reg_waddr  = fw_addr;
        fw_reg_wdata  = fw_data;
        eth_reg_wen   = eth_wen;
        eth_reg_waddr = eth_addr;
        eth_reg_wdata = eth_data;
        next_cycle();                   // write edge
        fw_reg_wen  = 1'b0;
        eth_reg_wen = 1'b0;
    endtask

    // status word at address 0, power enable is bit 19, eth wins
    task automatic note_status_write(input logic fw_wen, input addr_t fw_addr,
                                     input data_t fw_data, input logic eth_wen,
                                     input addr_t eth_addr, input data_t eth_data);
        if (eth_wen) begin
            if (eth_addr == 16'h0000)
                exp_pwr = eth_data[19];
        end else if (fw_wen && fw_addr == 16'h0000) begin
            exp_pwr = fw_data[19];
        end
    endtask

    // both addresses set, eth_read_en picks the owner
    task automatic drive_read(input addr_t fw_addr, input addr_t eth_addr, input logic eth_en,
                              output data_t got);
        fw_reg_raddr  = fw_addr;
        eth_reg_raddr = eth_addr;
        eth_read_en   = eth_en;
        @(negedge sysclk);              // reg_rdata settled mid-cycle
        got = reg_rdata;
        next_cycle();
    endtask

    task automatic set_feedback(input int chan, input cur_t value);
        case (chan)
            1:       cur_fb1 = value;
            2:       cur_fb2 = value;
            3:       cur_fb3 = value;
            4:       cur_fb4 = value;
            default: need_fields(0, 1);     // no such axis
        endcase
    endtask

    function automatic cur_t cmd_of(input int chan);
        case (chan)
            1:       return cur_cmd1;
            2:       return cur_cmd2;
            3:       return cur_cmd3;
            default: return cur_cmd4;
        endcase
    endfunction

    task automatic pulse_start();
        eth_sample_start = 1'b1;
        next_cycle();
        eth_sample_start = 1'b0;
    endtask

    // ----------------------------------------
    // trace reader
    // ----------------------------------------
    initial begin
        rst_n            = 1'b0;
        fw_reg_raddr     = 16'h7000;    // unmapped space
        fw_reg_waddr     = 16'h7000;
        fw_reg_wdata     = '0;
        fw_reg_wen       = 1'b0;
        eth_reg_raddr    = 16'h7000;
        eth_reg_waddr    = 16'h7000;
        eth_reg_wdata    = '0;
        eth_reg_wen      = 1'b0;
        eth_read_en      = 1'b0;
        eth_sample_start = 1'b0;
        board_id         = '0;
        cur_fb1          = 16'h8000;    // midscale, no current
        cur_fb2          = 16'h8000;
        cur_fb3          = 16'h8000;
        cur_fb4          = 16'h8000;
        first_stamp      = '0;
        exp_pwr          = 1'b0;        // off after reset
        fd = $fopen("verification/board_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verification/board_trace.txt");
            end_in_failure();
        end
        repeat (3) @(posedge sysclk);
        #2 rst_n = 1'b1;
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", op);
            if (rc != 1)
                continue;               // trailing blank lines
            if (op.getc(0) == "#") begin
                rc = $fgets(skip_line, fd);
                continue;
            end
            case (op)
                "W": begin
                    rc = $fscanf(fd, "%h %h %h %h %h %h", t_bit_a, t_addr_a, t_data_a,
                                 t_bit_b, t_addr_b, t_data_b);
                    need_fields(rc, 6);
                    drive_write(t_bit_a, t_addr_a, t_data_a, t_bit_b, t_addr_b, t_data_b);
                    note_status_write(t_bit_a, t_addr_a, t_data_a, t_bit_b, t_addr_b, t_data_b);
                end
                "R": begin
                    rc = $fscanf(fd, "%h %h %h %h", t_addr_a, t_addr_b, t_bit_a, t_data_a);
                    need_fields(rc, 4);
                    drive_read(t_addr_a, t_addr_b, t_bit_a, stamp);
                    check_data(stamp, t_data_a,
                               $sformatf("read fw %h eth %h en %b", t_addr_a, t_addr_b, t_bit_a));
                end
                "F": begin
                    rc = $fscanf(fd, "%h %h", t_chan, t_cur);
                    need_fields(rc, 2);
                    set_feedback(t_chan, t_cur);
                end
                "C": begin
                    rc = $fscanf(fd, "%h %h", t_chan, t_cur);
                    need_fields(rc, 2);
                    @(negedge sysclk);
                    check_cur(cmd_of(t_chan), t_cur, t_chan);
                    next_cycle();
                end
                "A": begin
                    rc = $fscanf(fd, "%h", t_mask);
                    need_fields(rc, 1);
                    @(negedge sysclk);
                    check_mask(amp_enable, t_mask);
                    check_flag(pwr_enable, exp_pwr, "pwr_enable");
                    next_cycle();
                end
                "B": begin
                    rc = $fscanf(fd, "%h", t_bit_a);
                    need_fields(rc, 1);
                    @(negedge sysclk);
                    check_flag(sample_busy, t_bit_a, "sample_busy");
                    next_cycle();
                end
                "I": begin
                    rc = $fscanf(fd, "%h", t_id);
                    need_fields(rc, 1);
                    board_id = t_id;
                end
                "N": begin
                    rc = $fscanf(fd, "%d", t_count);
                    need_fields(rc, 1);
                    repeat (t_count) next_cycle();
                end
                "S": pulse_start();
                "T": drive_read(16'h5000, 16'h7000, 1'b0, first_stamp);  // word 0
                "G": begin
                    drive_read(16'h5000, 16'h7000, 1'b0, stamp);
                    check_later(stamp, first_stamp);
                end
                default: begin
                    $display("unknown opcode %s in the trace file", op);
                    end_in_failure();
                end
            endcase
        end
        $fclose(fd);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/board_trace.txt
# fields are hex, except the N count which is decimal
# W fw_wen fw_waddr fw_wdata eth_wen eth_waddr eth_wdata | R fw_raddr eth_raddr eth_en expect
# F chan fb | C chan cmd | A mask | B busy | I board_id | S start | N cycles | T G word 0 stamps
I a
A 0
B 0
# command registers, fw then eth then both hosts at once
W 1 0011 ffff8100 0 7000 00000000
W 0 7000 00000000 1 0021 00007e00
W 1 0031 00008300 1 0031 00008400
W 0 7000 00000000 1 0041 00008050
R 0011 7000 0 00008100
R 7000 0021 1 00007e00
R 0031 7000 0 00008400
R 7000 0041 1 00008050
C 1 8100
C 2 7e00
C 3 8400
C 4 8050
# read arbitration and unmapped spaces
R 0011 0021 1 00007e00
R 0011 0021 0 00008100
R 3011 0021 0 00000000
R 0011 f041 1 00000000
# adc readback and board status
F 1 8123
F 2 7f00
F 3 8456
F 4 8000
R 0010 7000 0 00008123
R 7000 0020 1 00007f00
R 0030 7000 0 00008456
R 7000 0040 1 00008000
R 0000 7000 0 0a000000
# over-current trip on axis 2
W 1 0000 0008000f 0 7000 00000000
A f
R 0000 7000 0 0a08000f
F 2 9000
N 10
A d
R 7000 0000 1 0a08002f
F 2 7f00
W 1 0000 0008000f 0 7000 00000000
N 2
A f
R 0000 7000 0 0a08000f
# block sample, then a second one for the timestamp
S
B 1
N 8
B 0
R 5001 7000 0 00008123
R 5002 7000 0 00007f00
R 5003 7000 0 00008456
R 7000 5004 1 00008000
T
S
N 8
G
B 0

// File: all.f
+incdir+logic
logic/board_pkg.sv
logic/reg_bus_router.sv
logic/dac_cmd_regs.sv
logic/safety_check.sv
logic/board_regs.sv
logic/block_sampler.sv
logic/motor_board_top.sv
verification/tb_motor_board.sv
